// File: apb_intc.f
+incdir+tests
src/intc_cfg_pkg.sv
src/intc_reg_pkg.sv
src/priority_encoder.sv
src/irq_pending.sv
src/intc_apb_regs.sv
src/apb_intc.sv
tests/tb_apb_intc.sv

// File: tests/intc_vectors.txt
# columns: op addr data expect pslverr, all hex
# op W write, R read, S drive irq_src, I check irq; unused fields are 0
I 0 00000000 00000000 0
R 0 00000000 00000000 0
R 4 00000000 00000000 0
R C 00000000 00000000 0
# sources 0 and 2 rise while masked
S 0 00000005 00000000 0
R 0 00000000 00000005 0
I 0 00000000 00000000 0
W 4 00000004 00000000 0
I 0 00000000 00000001 0
R 4 00000000 00000004 0
R C 00000000 80000002 0
R 0 00000000 00000001 0
I 0 00000000 00000000 0
R C 00000000 00000000 0
W 4 00005A3C 00000000 0
R 4 00000000 00005A3C 0
W 4 0000FFFF 00000000 0
R 4 00000000 0000FFFF 0
I 0 00000000 00000001 0
# clear source 0 with its line still high
W 8 00000200 00000000 0
R 0 00000000 00000000 0
I 0 00000000 00000000 0
# edges on 6 7 13 15, source 2 held
S 0 0000A0C4 00000000 0
R 0 00000000 0000A0C0 0
I 0 00000000 00000001 0
R C 00000000 80000006 0
R C 00000000 80000007 0
R C 00000000 8000000D 0
R C 00000000 8000000F 0
R C 00000000 00000000 0
I 0 00000000 00000000 0
# set, unknown ops, clear
W 8 00000103 00000000 0
W 8 0000010A 00000000 0
W 8 00000303 00000000 0
W 8 00000005 00000000 0
R 0 00000000 00000408 0
W 8 00000203 00000000 0
R 0 00000000 00000400 0
R C 00000000 8000000A 0
# error responses leave state alone
W 8 00000105 00000000 0
W 0 0000FFFF 00000000 1
W C 00000001 00000000 1
W 6 0000FFFF 00000000 1
W 9 00000107 00000000 1
R 2 00000000 00000000 1
R F 00000000 00000000 1
R 4 00000000 0000FFFF 0
R 0 00000000 00000020 0
R C 00000000 80000005 0
I 0 00000000 00000000 0

// File: tests/tb_apb_tasks.svh
/* APB bus and check tasks */

// ends the run, every failure path comes through here
task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1);
endtask

// wrong value seen, report with the time and stop
task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    abort_run();
endtask

task automatic check_word(input intc_reg_pkg::reg_word_t got,
                          input intc_reg_pkg::reg_word_t exp, input string what);
    if (got !== exp) begin
        report_error($sformatf("%s read 0x%08h, expected 0x%08h", what, got, exp));
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        report_error($sformatf("%s is %b, expected %b", what, got, exp));
    end
endtask

// setup and access phase, sampled a quarter period into the access phase
task automatic apb_access(input logic write, input logic [intc_reg_pkg::addr_width-1:0] addr,
                          input intc_reg_pkg::reg_word_t wdata,
                          output intc_reg_pkg::reg_word_t rdata, output logic err);
    @(negedge clk);
    paddr   = addr;
    pwrite  = write;
    pwdata  = write ? wdata : '0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #(clk_period / 4);
    check_bit(pready, 1'b1, "pready in access phase");
    rdata = prdata;
    err   = pslverr;
    // back to idle once the transfer has completed
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic drive_sources(input logic [intc_cfg_pkg::num_src-1:0] pattern);
    @(negedge clk);
    irq_src = pattern;
endtask

task automatic check_irq(input logic exp);
    @(negedge clk);
    #(clk_period / 4);
    check_bit(irq, exp, "irq");
endtask

// File: tests/tb_apb_intc.sv
/* APB interrupt controller testbench */
`timescale 1ns/1ps

module tb_apb_intc;

    localparam int clk_period = 40;
    localparam int reset_cycles = 8;
    localparam int rand_rounds = 20;
    localparam string vec_path = "tests/intc_vectors.txt";

    logic                                clk;
    logic                                rst_n;
    logic [intc_reg_pkg::addr_width-1:0] paddr;
    logic                                psel;
    logic                                penable;
    logic                                pwrite;
    intc_reg_pkg::reg_word_t             pwdata;
    intc_reg_pkg::reg_word_t             prdata;
    logic                                pready;
    logic                                pslverr;
    logic [intc_cfg_pkg::num_src-1:0]    irq_src;
    logic                                irq;

    // one entry per vector line
    byte unsigned                        vec_op[$];
    logic [intc_reg_pkg::addr_width-1:0] vec_addr[$];
    intc_reg_pkg::reg_word_t             vec_data[$];
    intc_reg_pkg::reg_word_t             vec_exp[$];
    logic                                vec_err[$];
    logic                                vectors_loaded;
    int                                  seed;

    apb_intc dut0 (
        .clk (clk), .rst_n (rst_n), .paddr (paddr), .psel (psel), .penable (penable),
        .pwrite (pwrite), .pwdata (pwdata), .prdata (prdata), .pready (pready),
        .pslverr (pslverr), .irq_src (irq_src), .irq (irq)
    );

    `include "tb_apb_tasks.svh"

    // claim word from the fixed priority order, 0 when nothing competes
    function automatic intc_reg_pkg::reg_word_t expected_claim(
        input logic [intc_cfg_pkg::num_src-1:0] req);
        intc_reg_pkg::reg_word_t w;
        int i;
        w = '0;
        for (i = 0; i < intc_cfg_pkg::num_src; i++) begin
            int k;
            k = intc_cfg_pkg::lsb_first ? i : intc_cfg_pkg::num_src - 1 - i;
            if (req[k] && !w[intc_reg_pkg::claim_valid_bit]) begin
                w[intc_reg_pkg::claim_valid_bit]    = 1'b1;
                w[intc_cfg_pkg::id_width-1:0] = intc_cfg_pkg::id_width'(k);
            end
        end
        return w;
    endfunction

    task automatic load_vectors();
        int fd;
        int c;
        int n;
        logic [intc_reg_pkg::addr_width-1:0] a;
        intc_reg_pkg::reg_word_t d;
        intc_reg_pkg::reg_word_t e;
        logic r;
        fd = $fopen(vec_path, "r");
        if (fd == 0) begin
            $display("cannot open the vectors file %s", vec_path);
            abort_run();
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                // skip the rest of a comment line
                while (c != -1 && c != "\n") begin
                    c = $fgetc(fd);
                end
            end else if (c == "W" || c == "R" || c == "S" || c == "I") begin
                n = $fscanf(fd, "%h %h %h %h", a, d, e, r);
                if (n != 4) begin
                    $display("vector line for op %c has missing fields", c);
                    abort_run();
                end
                vec_op.push_back(c[7:0]);
                vec_addr.push_back(a);
                vec_data.push_back(d);
                vec_exp.push_back(e);
                vec_err.push_back(r);
            end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
                $display("unknown op %c in the vectors file", c);
                abort_run();
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    task automatic run_vectors();
        intc_reg_pkg::reg_word_t rd;
        logic err;
        int i;
        for (i = 0; i < vec_op.size(); i++) begin
            case (vec_op[i])
                "W": begin
                    apb_access(1'b1, vec_addr[i], vec_data[i], rd, err);
                    check_bit(err, vec_err[i], $sformatf("vector %0d pslverr", i));
                end
                "R": begin
                    apb_access(1'b0, vec_addr[i], '0, rd, err);
                    check_word(rd, vec_exp[i], $sformatf("vector %0d", i));
                    check_bit(err, vec_err[i], $sformatf("vector %0d pslverr", i));
                end
                "S": drive_sources(vec_data[i][intc_cfg_pkg::num_src-1:0]);
                default: check_irq(vec_exp[i][0]);
            endcase
        end
    endtask

    // random sources and masks, claims checked against a software model
    task automatic random_phase();
        logic [intc_cfg_pkg::num_src-1:0] model_pend;
        logic [intc_cfg_pkg::num_src-1:0] en_mask;
        logic [intc_cfg_pkg::num_src-1:0] pattern;
        logic [intc_cfg_pkg::num_src-1:0] prev_src;
        intc_reg_pkg::reg_word_t rd;
        intc_reg_pkg::reg_word_t exp_w;
        logic err;
        logic done;
        int rnd;
        int k;
        int round;
        drive_sources('0);
        prev_src = '0;
        // start from an empty pending register with CMD clears
        for (k = 0; k < intc_cfg_pkg::num_src; k++) begin
            apb_access(1'b1, intc_reg_pkg::addr_cmd,
                       (32'(intc_reg_pkg::cmd_clear) << 8) | 32'(k), rd, err);
            check_bit(err, 1'b0, "pslverr on CMD clear");
        end
        model_pend = '0;
        for (round = 0; round < rand_rounds; round++) begin
            rnd = $random(seed);
            en_mask = rnd[intc_cfg_pkg::num_src-1:0];
            rnd = $random(seed);
            pattern = rnd[intc_cfg_pkg::num_src-1:0];
            apb_access(1'b1, intc_reg_pkg::addr_enable, 32'(en_mask), rd, err);
            check_bit(err, 1'b0, "pslverr on ENABLE write");
            drive_sources(pattern);
            // only 0 to 1 transitions pend a source
            model_pend = model_pend | (pattern & ~prev_src);
            prev_src = pattern;
            apb_access(1'b0, intc_reg_pkg::addr_pending, '0, rd, err);
            check_word(rd, 32'(model_pend), $sformatf("round %0d PENDING", round));
            done = 1'b0;
            for (k = 0; k <= intc_cfg_pkg::num_src && !done; k++) begin
                exp_w = expected_claim(model_pend & en_mask);
                apb_access(1'b0, intc_reg_pkg::addr_claim, '0, rd, err);
                check_word(rd, exp_w, $sformatf("round %0d CLAIM", round));
                if (exp_w[intc_reg_pkg::claim_valid_bit]) begin
                    model_pend[exp_w[intc_cfg_pkg::id_width-1:0]] = 1'b0;
                end else begin
                    done = 1'b1;
                end
            end
            check_irq(1'b0);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // limit grows with the vector count and the random rounds
    initial begin
        int ops;
        wait (vectors_loaded);
        ops = vec_op.size() + intc_cfg_pkg::num_src + 2
            + rand_rounds * (intc_cfg_pkg::num_src + 5);
        repeat (ops * 10 + reset_cycles) @(posedge clk);
        $display("watchdog expired after %0d ops worth of cycles, the run is stuck", ops);
        abort_run();
    end

    initial begin
        rst_n          = 1'b0;
        paddr          = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        pwdata         = '0;
        irq_src        = '0;
        vectors_loaded = 1'b0;
        seed           = 14230;
        load_vectors();
        vectors_loaded = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        run_vectors();
        random_phase();
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: src/apb_intc.sv
/* APB interrupt controller */
`timescale 1ns/1ps

module apb_intc (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [intc_reg_pkg::addr_width-1:0] paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  intc_reg_pkg::reg_word_t             pwdata,
    output intc_reg_pkg::reg_word_t             prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  logic [intc_cfg_pkg::num_src-1:0]    irq_src,
    output logic                                irq
);

    // register block to pending logic
    logic                              enable_we;
    logic [intc_cfg_pkg::num_src-1:0]  enable_data;
    logic                              set_req;
    logic                              clr_req;
    logic [intc_cfg_pkg::id_width-1:0] cmd_id;
    logic                              claim_req;

    // pending logic outputs
    logic [intc_cfg_pkg::num_src-1:0]  pending;
    logic [intc_cfg_pkg::num_src-1:0]  enable;
    logic [intc_cfg_pkg::num_src-1:0]  active;

    // encoder result
    logic                              win_valid;
    logic [intc_cfg_pkg::id_width-1:0] win_id;

    // no wait states
    assign pready = 1'b1;

    intc_apb_regs regs0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pslverr     (pslverr),
        .pending     (pending),
        .enable      (enable),
        .win_valid   (win_valid),
        .win_id      (win_id),
        .enable_we   (enable_we),
        .enable_data (enable_data),
        .set_req     (set_req),
        .clr_req     (clr_req),
        .cmd_id      (cmd_id),
        .claim_req   (claim_req)
    );

    // claim always retires the current encoder winner
    irq_pending pend0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_src     (irq_src),
        .enable_we   (enable_we),
        .enable_data (enable_data),
        .set_req     (set_req),
        .clr_req     (clr_req),
        .cmd_id      (cmd_id),
        .claim_req   (claim_req),
        .claim_id    (win_id),
        .pending     (pending),
        .enable      (enable),
        .active      (active)
    );

    // one-hot output not needed here
    priority_encoder #(
        .width             (intc_cfg_pkg::num_src),
        .lsb_high_priority (intc_cfg_pkg::lsb_first)
    ) enc0 (
        .unencoded (active),
        .valid     (win_valid),
        .encoded   (win_id),
        .onehot    ()
    );

    // any enabled pending source raises the line
    assign irq = win_valid;

endmodule

// File: src/intc_apb_regs.sv
/* APB register block */
`timescale 1ns/1ps

module intc_apb_regs (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [intc_reg_pkg::addr_width-1:0]   paddr,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  intc_reg_pkg::reg_word_t               pwdata,
    output intc_reg_pkg::reg_word_t               prdata,
    output logic                                  pslverr,
    input  logic [intc_cfg_pkg::num_src-1:0]      pending,
    input  logic [intc_cfg_pkg::num_src-1:0]      enable,
    input  logic                                  win_valid,
    input  logic [intc_cfg_pkg::id_width-1:0]     win_id,
    output logic                                  enable_we,
    output logic [intc_cfg_pkg::num_src-1:0]      enable_data,
    output logic                                  set_req,
    output logic                                  clr_req,
    output logic [intc_cfg_pkg::id_width-1:0]     cmd_id,
    output logic                                  claim_req
);

    // a setup phase was seen on the previous clock
    logic setup_q;
    // qualified access phase
    logic access;

    // address hits
    logic hit_pending;
    logic hit_enable;
    logic hit_cmd;
    logic hit_claim;
    logic mapped;

    // write to a read-only register
    logic ro_write;
    logic wr_ok;
    logic rd_ok;

    // pwdata seen through the union
    intc_reg_pkg::wr_word_u wr_u;

    // track the phase so a held psel/penable cannot repeat an access
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= psel && !penable;
        end
    end

    assign access = psel && penable && setup_q;

    assign hit_pending = (paddr == intc_reg_pkg::addr_pending);
    assign hit_enable  = (paddr == intc_reg_pkg::addr_enable);
    assign hit_cmd     = (paddr == intc_reg_pkg::addr_cmd);
    assign hit_claim   = (paddr == intc_reg_pkg::addr_claim);
    assign mapped      = hit_pending | hit_enable | hit_cmd | hit_claim;

    // PENDING and CLAIM are read only
    assign ro_write = pwrite && (hit_pending || hit_claim);

    // error only during the access phase
    assign pslverr = access && (!mapped || ro_write);

    // legal writes go only to ENABLE and CMD
    assign wr_ok = access && pwrite && (hit_enable || hit_cmd);
    // legal reads are any mapped address
    assign rd_ok = access && !pwrite && mapped;

    assign wr_u = pwdata;

    // ENABLE takes the mask view
    assign enable_we   = wr_ok && hit_enable;
    assign enable_data = wr_u.mask.mask;

    // CMD takes the command view, unknown ops fall through silently
    assign set_req = wr_ok && hit_cmd && (wr_u.cmd.op == intc_reg_pkg::cmd_set);
    assign clr_req = wr_ok && hit_cmd && (wr_u.cmd.op == intc_reg_pkg::cmd_clear);
    assign cmd_id  = wr_u.cmd.id;

    // reading CLAIM with a winner retires that winner at this edge
    assign claim_req = rd_ok && hit_claim && win_valid;

    // read mux, zero outside a read access
    always_comb begin
        prdata = '0;
        if (rd_ok) begin
            case (paddr)
                intc_reg_pkg::addr_pending: begin
                    prdata[intc_cfg_pkg::num_src-1:0] = pending;
                end
                intc_reg_pkg::addr_enable: begin
                    prdata[intc_cfg_pkg::num_src-1:0] = enable;
                end
                intc_reg_pkg::addr_claim: begin
                    // pre-clear view, id forced to 0 with no winner
                    prdata[intc_reg_pkg::claim_valid_bit] = win_valid;
                    prdata[intc_cfg_pkg::id_width-1:0]    = win_valid ? win_id : '0;
                end
                default: begin
                    // CMD reads back as zero
                    prdata = '0;
                end
            endcase
        end
    end

endmodule

// File: src/irq_pending.sv
/* source capture and pending bits */
`timescale 1ns/1ps

module irq_pending (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [intc_cfg_pkg::num_src-1:0]  irq_src,
    input  logic                              enable_we,
    input  logic [intc_cfg_pkg::num_src-1:0]  enable_data,
    input  logic                              set_req,
    input  logic                              clr_req,
    input  logic [intc_cfg_pkg::id_width-1:0] cmd_id,
    input  logic                              claim_req,
    input  logic [intc_cfg_pkg::id_width-1:0] claim_id,
    output logic [intc_cfg_pkg::num_src-1:0]  pending,
    output logic [intc_cfg_pkg::num_src-1:0]  enable,
    output logic [intc_cfg_pkg::num_src-1:0]  active
);

    // last sample of each source line
    logic [intc_cfg_pkg::num_src-1:0] src_q;
    logic [intc_cfg_pkg::num_src-1:0] pending_q;
    logic [intc_cfg_pkg::num_src-1:0] enable_q;

    // per-bit update terms
    logic [intc_cfg_pkg::num_src-1:0] rise;
    logic [intc_cfg_pkg::num_src-1:0] set_vec;
    logic [intc_cfg_pkg::num_src-1:0] clr_vec;
    logic [intc_cfg_pkg::num_src-1:0] claim_vec;
    logic [intc_cfg_pkg::num_src-1:0] pending_nxt;

    // 0 to 1 transition since the last clock
    assign rise = irq_src & ~src_q;

    // decode the commanded id and the claimed id into bit vectors
    always_comb begin
        for (int i = 0; i < intc_cfg_pkg::num_src; i++) begin
            set_vec[i]   = set_req && (cmd_id == intc_cfg_pkg::id_width'(i));
            clr_vec[i]   = clr_req && (cmd_id == intc_cfg_pkg::id_width'(i));
            claim_vec[i] = claim_req && (claim_id == intc_cfg_pkg::id_width'(i));
        end
    end

    // clears apply first so a same-cycle edge or set survives
    assign pending_nxt = (pending_q & ~(clr_vec | claim_vec)) | rise | set_vec;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            src_q     <= '0;
            pending_q <= '0;
            enable_q  <= '0;
        end else begin
            src_q     <= irq_src;
            pending_q <= pending_nxt;
            // mask loads only on an ENABLE write
            if (enable_we) begin
                enable_q <= enable_data;
            end
        end
    end

    assign pending = pending_q;
    assign enable  = enable_q;

    // requests that may compete for the output
    assign active = pending_q & enable_q;

endmodule

// File: src/priority_encoder.sv
/* tree priority encoder */
`timescale 1ns/1ps

module priority_encoder #(
    parameter int width = 4,
    // 1 makes bit 0 the winner over higher bits
    parameter bit lsb_high_priority = 1'b0
) (
    input  logic [width-1:0]         unencoded,
    output logic                     valid,
    output logic [$clog2(width)-1:0] encoded,
    output logic [width-1:0]         onehot
);

    // input widened to the next power of two, extra bits stay low
    logic [(2 ** $clog2(width))-1:0] padded;
    // node flags per tree level, level 0 is the padded input
    logic [(2 ** $clog2(width))-1:0] node_v [$clog2(width)+1];
    // partial index per node, only the low l bits matter at level l
    logic [$clog2(width)-1:0] node_idx [$clog2(width)+1][2 ** $clog2(width)];

    assign padded = (2 ** $clog2(width))'(unencoded);

    genvar l, n;

    // leaves carry the raw request and an empty index
    for (n = 0; n < (2 ** $clog2(width)); n++) begin : g_leaf
        assign node_v[0][n]   = padded[n];
        assign node_idx[0][n] = '0;
    end

    // each level merges pairs and adds one index bit on top
    for (l = 1; l <= $clog2(width); l++) begin : g_level
        for (n = 0; n < (2 ** $clog2(width)); n++) begin : g_node
            if (n < ((2 ** $clog2(width)) >> l)) begin : g_merge
                logic pick_hi;

                if (lsb_high_priority) begin : g_lsb
                    // lower half wins whenever it has a request
                    assign pick_hi = !node_v[l-1][2*n];
                end else begin : g_msb
                    // upper half wins whenever it has a request
                    assign pick_hi = node_v[l-1][2*n+1];
                end

                assign node_v[l][n] = node_v[l-1][2*n] | node_v[l-1][2*n+1];
                // upper child sets index bit l-1
                assign node_idx[l][n] = pick_hi
                    ? (node_idx[l-1][2*n+1] | (($clog2(width))'(1) << (l - 1)))
                    : node_idx[l-1][2*n];
            end else begin : g_idle
                // slots past the end of this level
                assign node_v[l][n]   = 1'b0;
                assign node_idx[l][n] = '0;
            end
        end
    end

    // root of the tree
    assign valid   = node_v[$clog2(width)][0];
    assign encoded = node_idx[$clog2(width)][0];

    // decoded winner, all zero with no request
    assign onehot = valid ? (width'(1) << encoded) : '0;

endmodule

// File: src/intc_reg_pkg.sv
/* APB register map */
package intc_reg_pkg;

    // byte address width of the register window
    localparam int addr_width = 4;

    // one APB data word
    typedef logic [31:0] reg_word_t;

    // register offsets
    localparam logic [addr_width-1:0] addr_pending = 4'h0;
    localparam logic [addr_width-1:0] addr_enable  = 4'h4;
    localparam logic [addr_width-1:0] addr_cmd     = 4'h8;
    localparam logic [addr_width-1:0] addr_claim   = 4'hC;

    // command opcodes in the op field of a CMD write
    localparam logic [1:0] cmd_set   = 2'd1;
    localparam logic [1:0] cmd_clear = 2'd2;

    // position of the valid flag in the claim word
    localparam int claim_valid_bit = 31;

    // ENABLE write, mask in the low half
    typedef struct packed {
        logic [31-intc_cfg_pkg::num_src:0] unused;
        logic [intc_cfg_pkg::num_src-1:0]  mask;
    } mask_view_t;

    // CMD write, op at 9:8 and source id at the bottom
    typedef struct packed {
        logic [21:0]                       rsv_hi;
        logic [1:0]                        op;
        logic [7-intc_cfg_pkg::id_width:0] rsv_lo;
        logic [intc_cfg_pkg::id_width-1:0] id;
    } cmd_view_t;

    // same written word, two readings chosen by address
    typedef union packed {
        mask_view_t mask;
        cmd_view_t  cmd;
    } wr_word_u;

endpackage

// File: src/intc_cfg_pkg.sv
/* interrupt controller sizing */
package intc_cfg_pkg;

    // number of interrupt source lines
    localparam int num_src = 16;

    // bits needed to name one source
    localparam int id_width = $clog2(num_src);

    // fixed priority order by source index
    // 1 gives source 0 the highest priority, 0 gives it the lowest
    localparam bit lsb_first = 1'b1;

    // the claim word packs the id into the low bits, keep it narrow
    // enough to leave bit 31 for the valid flag
    // the mask view of a written word also needs num_src to fit in 16 bits
    // since the command op sits at bits 9:8

    // source lines are sampled on clk
    // no synchronizer is provided, callers drive them from the same domain

    // ids run from 0 to num_src-1
    // ids at or above num_src never appear on the encoder output
    // because padded inputs are tied low

endpackage
